/* dcache_cfg_pkg.sv */
package dcache_cfg_pkg;

    // CPU side
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;

    // Geometry
    localparam int WAYS           = 2;
    localparam int SETS           = 16;
    localparam int WORDS_PER_LINE = 4;

    // Address fields, from the low end up
    localparam int BYTE_OFFSET_WIDTH = 2;
    localparam int WORD_OFFSET_WIDTH = 2;
    localparam int INDEX_WIDTH       = 4;
    localparam int TAG_WIDTH         =
        ADDR_WIDTH - INDEX_WIDTH - WORD_OFFSET_WIDTH - BYTE_OFFSET_WIDTH;

    typedef logic [WORD_WIDTH-1:0]        word_t;
    typedef logic [WORD_WIDTH/8-1:0]      byte_en_t;
    typedef logic [INDEX_WIDTH-1:0]       index_t;
    typedef logic [WORD_OFFSET_WIDTH-1:0] word_offset_t;

    // One tag RAM entry
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    // Word 0 sits at the lowest address of the line
    typedef logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] line_t;

    typedef logic [WAYS-1:0]         way_sel_t;
    typedef logic [$clog2(WAYS)-1:0] way_idx_t;

endpackage

/* dcache_bus_pkg.sv */
package dcache_bus_pkg;

    // Memory bus data path
    localparam int BUS_DATA_WIDTH = 32;

    // Every transfer is an incrementing burst over one line
    localparam int BEATS_PER_LINE = 4;

    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_t;

endpackage

/* dcache_way_ram.sv */
`timescale 1ns/1ps

module dcache_way_ram #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output payload_t                 rdata
);

    // One entry per set
    payload_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read is combinational so hit detection sees it in the same cycle
    assign rdata = mem[raddr];

endmodule

/* dcache_refill.sv */
`timescale 1ns/1ps

module dcache_refill
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [ADDR_WIDTH-1:0]     line_addr,
    output logic                      done,
    output line_t                     line,
    output logic                      arvalid,
    output logic [ADDR_WIDTH-1:0]     araddr,
    input  logic                      arready,
    input  logic                      rvalid,
    input  logic [BUS_DATA_WIDTH-1:0] rdata,
    input  logic                      rlast,
    output logic                      rready
);

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ADDR,
        RF_DATA
    } rf_state_t;

    rf_state_t             state;
    beat_cnt_t             beat_cnt;
    logic [ADDR_WIDTH-1:0] addr_q;

    assign arvalid = (state == RF_ADDR);
    assign araddr  = addr_q;
    assign rready  = (state == RF_DATA) && rvalid;
    // Last beat lands in the line on this edge
    assign done    = (state == RF_DATA) && rvalid && rlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= RF_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                RF_IDLE: begin
                    if (start) begin
                        state    <= RF_ADDR;
                        beat_cnt <= '0;
                    end
                end
                RF_ADDR: begin
                    if (arready) begin
                        state <= RF_DATA;
                    end
                end
                RF_DATA: begin
                    if (rvalid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rlast) begin
                            state <= RF_IDLE;
                        end
                    end
                end
                default: state <= RF_IDLE;
            endcase
        end
    end

    // Address and collected beats
    always_ff @(posedge clk) begin
        if (state == RF_IDLE && start) begin
            addr_q <= {line_addr[ADDR_WIDTH-1:BYTE_OFFSET_WIDTH+WORD_OFFSET_WIDTH],
                       {(BYTE_OFFSET_WIDTH + WORD_OFFSET_WIDTH){1'b0}}};
        end
        if (state == RF_DATA && rvalid) begin
            line[beat_cnt] <= rdata;
        end
    end

endmodule

/* dcache_writeback.sv */
`timescale 1ns/1ps

module dcache_writeback
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [ADDR_WIDTH-1:0]     line_addr,
    input  line_t                     line,
    output logic                      busy,
    output logic                      awvalid,
    output logic [ADDR_WIDTH-1:0]     awaddr,
    input  logic                      awready,
    output logic                      wvalid,
    output logic [BUS_DATA_WIDTH-1:0] wdata,
    output logic                      wlast,
    input  logic                      wready,
    input  logic                      bvalid,
    output logic                      bready
);

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,
        WB_DATA,
        WB_RESP
    } wb_state_t;

    wb_state_t             state;
    beat_cnt_t             beat_cnt;
    logic [ADDR_WIDTH-1:0] addr_q;
    line_t                 line_q;

    assign busy    = (state != WB_IDLE);
    assign awvalid = (state == WB_ADDR);
    assign awaddr  = addr_q;
    assign wvalid  = (state == WB_DATA);
    assign wdata   = line_q[beat_cnt];
    assign wlast   = (beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 1));
    // Response code is not checked
    assign bready  = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= WB_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (start) begin
                        state <= WB_ADDR;
                    end
                end
                WB_ADDR: begin
                    beat_cnt <= '0;
                    if (awready) begin
                        state <= WB_DATA;
                    end
                end
                WB_DATA: begin
                    if (wready) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (wlast) begin
                            state <= WB_RESP;
                        end
                    end
                end
                WB_RESP: begin
                    if (bvalid) begin
                        state <= WB_IDLE;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

    // Victim copy, so the way can be refilled meanwhile
    always_ff @(posedge clk) begin
        if (state == WB_IDLE && start) begin
            addr_q <= line_addr;
            line_q <= line;
        end
    end

endmodule

/* dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [ADDR_WIDTH-1:0]   address,
    input  logic                    read,
    input  logic                    write,
    input  byte_en_t                byteenable,
    input  word_t                   wrdata,
    output word_t                   rddata,
    output logic                    stall,
    input  tag_entry_t [WAYS-1:0]   tag_rdata,
    input  line_t [WAYS-1:0]        line_rdata,
    output index_t                  ram_index,
    output index_t                  raddr,
    output way_sel_t                tag_we,
    output tag_entry_t              tag_wdata,
    output way_sel_t                line_we,
    output line_t                   line_wdata,
    output logic                    wb_start,
    output logic [ADDR_WIDTH-1:0]   wb_addr,
    output line_t                   wb_line,
    input  logic                    wb_busy,
    output logic                    rf_start,
    output logic [ADDR_WIDTH-1:0]   rf_addr,
    input  logic                    rf_done,
    input  line_t                   rf_line
);

    typedef enum logic [2:0] {
        SWEEP,
        IDLE,
        EVICT,
        WB_WAIT,
        FILL,
        DONE
    } state_t;

    state_t                 state, state_d;
    index_t                 sweep_cnt;
    logic [7:0]             lfsr;
    way_idx_t               victim;
    tag_entry_t             victim_tag;
    logic                   victim_dirty;
    logic [TAG_WIDTH-1:0]   req_tag;
    index_t                 req_index;
    word_offset_t           req_offset;
    byte_en_t               wr_be;
    way_sel_t               hit;
    logic                   any_hit;
    logic                   miss;
    line_t                  hit_line;

    // Merge the write bytes into one word of a line
    function automatic line_t merge_line(input line_t base, input word_offset_t pos,
                                         input byte_en_t be, input word_t data);
        line_t merged;
        merged = base;
        for (int b = 0; b < WORD_WIDTH / 8; b++) begin
            if (be[b]) begin
                merged[pos][8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign req_tag    = address[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign req_index  = address[BYTE_OFFSET_WIDTH+WORD_OFFSET_WIDTH +: INDEX_WIDTH];
    assign req_offset = address[BYTE_OFFSET_WIDTH +: WORD_OFFSET_WIDTH];
    assign wr_be      = write ? byteenable : '0;

    always_comb begin
        hit_line = '0;
        for (int i = 0; i < WAYS; i++) begin
            hit[i] = tag_rdata[i].valid && (tag_rdata[i].tag == req_tag);
            if (hit[i]) begin
                hit_line = line_rdata[i];
            end
        end
    end

    assign any_hit = |hit;
    assign miss    = (read || write) && !any_hit;
    assign stall   = (state != IDLE) || miss;

    // Victim stays fixed while the miss is handled
    assign victim       = lfsr[$bits(way_idx_t)-1:0];
    assign victim_tag   = tag_rdata[victim];
    assign victim_dirty = victim_tag.valid && victim_tag.dirty;

    // Bursts always start at beat 0 of the line
    assign wb_start = (state == EVICT) && victim_dirty;
    assign wb_addr  = {victim_tag.tag, req_index, beat_cnt_t'(0), {BYTE_OFFSET_WIDTH{1'b0}}};
    assign wb_line  = line_rdata[victim];
    assign rf_start = ((state == EVICT) && !victim_dirty) || ((state == WB_WAIT) && !wb_busy);
    assign rf_addr  = {req_tag, req_index, beat_cnt_t'(0), {BYTE_OFFSET_WIDTH{1'b0}}};

    assign raddr     = req_index;
    assign ram_index = (state == SWEEP) ? sweep_cnt : req_index;

    // RAM write control
    always_comb begin
        tag_we          = '0;
        line_we         = '0;
        tag_wdata.valid = 1'b1;
        tag_wdata.dirty = write;
        tag_wdata.tag   = req_tag;
        line_wdata      = merge_line(hit_line, req_offset, wr_be, wrdata);
        case (state)
            SWEEP: begin
                tag_we    = '1;
                tag_wdata = '0;
            end
            IDLE: begin
                if (write && any_hit) begin
                    tag_we  = hit;
                    line_we = hit;
                end
            end
            DONE: begin
                tag_we[victim]  = 1'b1;
                line_we[victim] = 1'b1;
                line_wdata      = merge_line(rf_line, req_offset, wr_be, wrdata);
            end
            default: ;
        endcase
    end

    always_comb begin
        state_d = state;
        case (state)
            SWEEP:   if (&sweep_cnt) state_d = IDLE;
            IDLE:    if (miss) state_d = EVICT;
            EVICT:   state_d = victim_dirty ? WB_WAIT : FILL;
            WB_WAIT: if (!wb_busy) state_d = FILL;
            FILL:    if (rf_done) state_d = DONE;
            DONE:    state_d = IDLE;
            default: state_d = SWEEP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SWEEP;
            sweep_cnt <= '0;
            lfsr      <= 8'h01;
        end else begin
            state <= state_d;
            if (state == SWEEP) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
            // Step x^8 + x^6 + x^5 + x^4 + 1 once per miss
            if (state == IDLE && miss) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && read && any_hit) begin
            rddata <= hit_line[req_offset];
        end
    end

endmodule

/* dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // CPU data port
    input  logic [ADDR_WIDTH-1:0] address,
    input  logic                  read,
    input  logic                  write,
    input  byte_en_t              byteenable,
    input  word_t                 wrdata,
    output word_t                 rddata,
    output logic                  stall,
    // Memory read channels
    output logic                  arvalid,
    output logic [ADDR_WIDTH-1:0] araddr,
    input  logic                  arready,
    input  logic                  rvalid,
    input  word_t                 rdata,
    input  logic                  rlast,
    output logic                  rready,
    // Memory write channels
    output logic                  awvalid,
    output logic [ADDR_WIDTH-1:0] awaddr,
    input  logic                  awready,
    output logic                  wvalid,
    output word_t                 wdata,
    output logic                  wlast,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready
);

    tag_entry_t [WAYS-1:0] tag_rdata;
    line_t [WAYS-1:0]      line_rdata;
    index_t                ram_index;
    index_t                raddr;
    way_sel_t              tag_we;
    tag_entry_t            tag_wdata;
    way_sel_t              line_we;
    line_t                 line_wdata;
    logic                  wb_start;
    logic [ADDR_WIDTH-1:0] wb_addr;
    line_t                 wb_line;
    logic                  wb_busy;
    logic                  rf_start;
    logic [ADDR_WIDTH-1:0] rf_addr;
    logic                  rf_done;
    line_t                 rf_line;

    for (genvar i = 0; i < WAYS; i++) begin : gen_way
        dcache_way_ram #(
            .payload_t (tag_entry_t),
            .DEPTH     (SETS)
        ) i_tag_ram (
            .clk   (clk),
            .we    (tag_we[i]),
            .waddr (ram_index),
            .wdata (tag_wdata),
            .raddr (raddr),
            .rdata (tag_rdata[i])
        );

        dcache_way_ram #(
            .payload_t (line_t),
            .DEPTH     (SETS)
        ) i_line_ram (
            .clk   (clk),
            .we    (line_we[i]),
            .waddr (ram_index),
            .wdata (line_wdata),
            .raddr (raddr),
            .rdata (line_rdata[i])
        );
    end

    dcache_ctrl i_ctrl (
        .clk        (clk),
        .rst        (rst),
        .address    (address),
        .read       (read),
        .write      (write),
        .byteenable (byteenable),
        .wrdata     (wrdata),
        .rddata     (rddata),
        .stall      (stall),
        .tag_rdata  (tag_rdata),
        .line_rdata (line_rdata),
        .ram_index  (ram_index),
        .raddr      (raddr),
        .tag_we     (tag_we),
        .tag_wdata  (tag_wdata),
        .line_we    (line_we),
        .line_wdata (line_wdata),
        .wb_start   (wb_start),
        .wb_addr    (wb_addr),
        .wb_line    (wb_line),
        .wb_busy    (wb_busy),
        .rf_start   (rf_start),
        .rf_addr    (rf_addr),
        .rf_done    (rf_done),
        .rf_line    (rf_line)
    );

    dcache_refill i_refill (
        .clk       (clk),
        .rst       (rst),
        .start     (rf_start),
        .line_addr (rf_addr),
        .done      (rf_done),
        .line      (rf_line),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rlast     (rlast),
        .rready    (rready)
    );

    dcache_writeback i_writeback (
        .clk       (clk),
        .rst       (rst),
        .start     (wb_start),
        .line_addr (wb_addr),
        .line      (wb_line),
        .busy      (wb_busy),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .awready   (awready),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wlast     (wlast),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready)
    );

endmodule

/* tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model
    import dcache_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_en,
    input  logic                  arvalid,
    input  logic [ADDR_WIDTH-1:0] araddr,
    output logic                  arready,
    output logic                  rvalid,
    output word_t                 rdata,
    output logic                  rlast,
    input  logic                  rready,
    input  logic                  awvalid,
    input  logic [ADDR_WIDTH-1:0] awaddr,
    output logic                  awready,
    input  logic                  wvalid,
    input  word_t                 wdata,
    input  logic                  wlast,
    output logic                  wready,
    output logic                  bvalid,
    input  logic                  bready,
    output int                    rd_bursts,
    output int                    wr_bursts
);

    // 4 KiB of backing store, addressed by word
    localparam int MEM_WORDS = 1024;

    word_t      mem [MEM_WORDS];
    logic [2:0] tick = '0;
    logic       rd_active = 1'b0;
    logic       wr_active = 1'b0;
    logic [9:0] rd_word = '0;
    logic [9:0] wr_word = '0;
    logic       gate;

    initial begin
        bvalid    = 1'b0;
        rd_bursts = 0;
        wr_bursts = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = i ^ 32'h5a5a0000;
        end
    end

    // Drop ready and valid on two of every eight cycles when stalling
    assign gate = !stall_en || (tick != 3'd2 && tick != 3'd5);

    assign arready = gate && !rd_active;
    assign rvalid  = rd_active && gate;
    assign rdata   = mem[rd_word];
    assign rlast   = &rd_word[1:0];
    assign awready = gate && !wr_active && !bvalid;
    assign wready  = wr_active && gate;

    always @(posedge clk) begin
        if (rst) begin
            tick      <= '0;
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            bvalid    <= 1'b0;
            rd_bursts <= 0;
            wr_bursts <= 0;
        end else begin
            tick <= tick + 1'b1;
            if (arvalid && arready) begin
                rd_active <= 1'b1;
                rd_word   <= araddr[11:2];
                rd_bursts <= rd_bursts + 1;
            end
            if (rvalid && rready) begin
                rd_word <= rd_word + 1'b1;
                if (rlast) begin
                    rd_active <= 1'b0;
                end
            end
            if (awvalid && awready) begin
                wr_active <= 1'b1;
                wr_word   <= awaddr[11:2];
                wr_bursts <= wr_bursts + 1;
            end
            if (wvalid && wready) begin
                mem[wr_word] <= wdata;
                wr_word      <= wr_word + 1'b1;
                if (wlast) begin
                    wr_active <= 1'b0;
                    bvalid    <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

endmodule

/* tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache
    import dcache_cfg_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 5;
    localparam int SWEEP_LIMIT = 40;
    localparam int STALL_LIMIT = 200;
    localparam int RANDOM_OPS  = 200;

    localparam logic [1:0] MISS_NO  = 2'd0;
    localparam logic [1:0] MISS_YES = 2'd1;
    localparam logic [1:0] MISS_ANY = 2'd2;

    typedef struct packed {
        logic        is_write;
        logic [31:0] addr;
        byte_en_t    be;
        word_t       data;
        logic [1:0]  expect_miss;
    } stim_t;

    // Sets 0 and 2 for hits and merges, set 5 for evictions
    localparam stim_t STIM [15] = '{
        '{1'b0, 32'h0000_0104, 4'hf, 32'h0000_0000, MISS_YES},
        '{1'b0, 32'h0000_0108, 4'hf, 32'h0000_0000, MISS_NO},
        '{1'b1, 32'h0000_010c, 4'h3, 32'hdead_beef, MISS_NO},
        '{1'b0, 32'h0000_010c, 4'hf, 32'h0000_0000, MISS_NO},
        '{1'b0, 32'h0000_0100, 4'hf, 32'h0000_0000, MISS_NO},
        '{1'b1, 32'h0000_0224, 4'h8, 32'h1122_3344, MISS_YES},
        '{1'b0, 32'h0000_0224, 4'hf, 32'h0000_0000, MISS_NO},
        '{1'b1, 32'h0000_0228, 4'hf, 32'hcafe_f00d, MISS_NO},
        '{1'b1, 32'h0000_0050, 4'hf, 32'ha5a5_0001, MISS_YES},
        '{1'b1, 32'h0000_0154, 4'h6, 32'h0102_0304, MISS_YES},
        '{1'b1, 32'h0000_0258, 4'hf, 32'h0bad_f00d, MISS_YES},
        '{1'b0, 32'h0000_0050, 4'hf, 32'h0000_0000, MISS_ANY},
        '{1'b0, 32'h0000_0154, 4'hf, 32'h0000_0000, MISS_ANY},
        '{1'b0, 32'h0000_0258, 4'hf, 32'h0000_0000, MISS_ANY},
        '{1'b0, 32'h0000_005c, 4'hf, 32'h0000_0000, MISS_ANY}
    };

    logic                  clk;
    logic                  rst;
    logic [ADDR_WIDTH-1:0] address;
    logic                  read;
    logic                  write;
    byte_en_t              byteenable;
    word_t                 wrdata;
    word_t                 rddata;
    logic                  stall;
    logic                  arvalid;
    logic [ADDR_WIDTH-1:0] araddr;
    logic                  arready;
    logic                  rvalid;
    word_t                 rdata;
    logic                  rlast;
    logic                  rready;
    logic                  awvalid;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic                  awready;
    logic                  wvalid;
    word_t                 wdata;
    logic                  wlast;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;
    logic                  stall_en;
    int                    rd_bursts;
    int                    wr_bursts;

    // Expected memory image, one entry per word
    word_t       ref_mem [1024];
    logic [31:0] awaddr_q;
    int          wb_beat;
    logic [31:0] seed;

    dcache_top i_dcache_top (
        .clk        (clk),
        .rst        (rst),
        .address    (address),
        .read       (read),
        .write      (write),
        .byteenable (byteenable),
        .wrdata     (wrdata),
        .rddata     (rddata),
        .stall      (stall),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rlast      (rlast),
        .rready     (rready),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wlast      (wlast),
        .wready     (wready),
        .bvalid     (bvalid),
        .bready     (bready)
    );

    tb_mem_model i_mem (
        .clk       (clk),
        .rst       (rst),
        .stall_en  (stall_en),
        .arvalid   (arvalid),
        .araddr    (araddr),
        .arready   (arready),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .rlast     (rlast),
        .rready    (rready),
        .awvalid   (awvalid),
        .awaddr    (awaddr),
        .awready   (awready),
        .wvalid    (wvalid),
        .wdata     (wdata),
        .wlast     (wlast),
        .wready    (wready),
        .bvalid    (bvalid),
        .bready    (bready),
        .rd_bursts (rd_bursts),
        .wr_bursts (wr_bursts)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input byte_en_t be,
                                          input word_t data);
        word_t result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // One CPU access, held until the cache accepts it
    task automatic apply_access(input logic is_write, input logic [31:0] addr,
                                input byte_en_t be, input word_t data,
                                input logic [1:0] expect_miss);
        int    waited;
        int    bursts_before;
        logic  missed;
        word_t expected;
        waited        = 0;
        bursts_before = rd_bursts;
        @(posedge clk);
        #DRIVE_DELAY;
        address    = addr;
        read       = !is_write;
        write      = is_write;
        byteenable = be;
        wrdata     = data;
        @(negedge clk);
        missed = stall;
        if (expect_miss != MISS_ANY) begin
            assert (missed == expect_miss[0]) else begin
                $display("FAILED stall: got %h expected %h at address %h",
                         missed, expect_miss[0], addr);
                abort_run();
            end
        end
        while (stall) begin
            waited++;
            assert (waited < STALL_LIMIT) else begin
                $display("Timeout: stall stayed high for the request at address %h", addr);
                abort_run();
            end
            @(negedge clk);
        end
        // A miss refills with exactly one read burst, a hit with none
        assert (rd_bursts == bursts_before + (missed ? 1 : 0)) else begin
            $display("FAILED rd_bursts: got %h expected %h",
                     rd_bursts, bursts_before + (missed ? 1 : 0));
            abort_run();
        end
        @(posedge clk);
        #DRIVE_DELAY;
        read  = 1'b0;
        write = 1'b0;
        if (is_write) begin
            ref_mem[addr[11:2]] = merge_bytes(ref_mem[addr[11:2]], be, data);
        end else begin
            @(negedge clk);
            expected = ref_mem[addr[11:2]];
            assert (rddata == expected) else begin
                $display("FAILED rddata: got %h expected %h at address %h",
                         rddata, expected, addr);
                abort_run();
            end
        end
    endtask

    // Bus monitor for addresses, ready outputs, wlast position and write-back data
    always @(negedge clk) begin
        if (!rst) begin
            assert (rready === rvalid) else begin
                $display("FAILED rready: got %h expected %h", rready, rvalid);
                abort_run();
            end
            assert (bready === 1'b1) else begin
                $display("FAILED bready: got %h expected %h", bready, 1'b1);
                abort_run();
            end
            if (arvalid && arready) begin
                assert (araddr == {address[31:4], 4'h0}) else begin
                    $display("FAILED araddr: got %h expected %h", araddr,
                             {address[31:4], 4'h0});
                    abort_run();
                end
            end
            if (awvalid && awready) begin
                // The victim shares the set of the request but not its tag
                assert (awaddr[7:0] == {address[7:4], 4'h0} &&
                        awaddr[31:8] != address[31:8]) else begin
                    $display("FAILED awaddr: got %h expected a line of set %h other than %h",
                             awaddr, address[7:4], {address[31:4], 4'h0});
                    abort_run();
                end
                awaddr_q = awaddr;
                wb_beat  = 0;
            end
            if (wvalid && wready) begin
                assert (wlast == (wb_beat == 3)) else begin
                    $display("FAILED wlast: got %h expected %h", wlast, wb_beat == 3);
                    abort_run();
                end
                assert (wdata == ref_mem[awaddr_q[11:2] + wb_beat]) else begin
                    $display("FAILED wdata: got %h expected %h",
                             wdata, ref_mem[awaddr_q[11:2] + wb_beat]);
                    abort_run();
                end
                wb_beat++;
            end
        end
    end

    initial begin
        int          sweep;
        logic [31:0] r_addr;
        word_t       r_data;
        clk        = 1'b0;
        rst        = 1'b1;
        address    = '0;
        read       = 1'b0;
        write      = 1'b0;
        byteenable = '0;
        wrdata     = '0;
        stall_en   = 1'b0;
        seed       = 32'h4a56;
        awaddr_q   = '0;
        wb_beat    = 0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = i ^ 32'h5a5a0000;
        end

        @(posedge clk);
        @(negedge clk);
        assert (stall === 1'b1) else begin
            $display("FAILED stall: got %h expected %h during reset", stall, 1'b1);
            abort_run();
        end
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Tag sweep, no bus traffic allowed
        sweep = 0;
        @(negedge clk);
        while (stall) begin
            sweep++;
            assert (!arvalid && !awvalid) else begin
                $display("FAILED arvalid/awvalid: got %h/%h expected 0/0 during sweep",
                         arvalid, awvalid);
                abort_run();
            end
            assert (sweep <= SWEEP_LIMIT) else begin
                $display("Timeout: the tag sweep did not finish within %0d cycles",
                         SWEEP_LIMIT);
                abort_run();
            end
            @(negedge clk);
        end
        assert (sweep >= SETS) else begin
            $display("FAILED sweep cycles: got %h expected %h", sweep, SETS);
            abort_run();
        end

        foreach (STIM[i]) begin
            apply_access(STIM[i].is_write, STIM[i].addr, STIM[i].be, STIM[i].data,
                         STIM[i].expect_miss);
        end
        assert (wr_bursts > 0) else begin
            $display("No write burst was seen although a dirty line had to be evicted");
            abort_run();
        end

        // Random traffic over sets 8 to 11 and tags 0 to 5 with bus stalls
        stall_en = 1'b1;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            seed   = lcg_next(seed);
            r_addr = ((seed[31:16] % 6) << 8) | ((8 + seed[15:14]) << 4) | (seed[13:12] << 2);
            r_data = lcg_next(seed);
            apply_access(seed[11], r_addr, seed[10:7], r_data, MISS_ANY);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

/* sources.f */
dcache_cfg_pkg.sv
dcache_bus_pkg.sv
dcache_way_ram.sv
dcache_refill.sv
dcache_writeback.sv
dcache_ctrl.sv
dcache_top.sv
tb_mem_model.sv
tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - dcache_cfg_pkg.sv
  - dcache_bus_pkg.sv
  - dcache_way_ram.sv
  - dcache_refill.sv
  - dcache_writeback.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_dcache.sv
